//--- dv/rom_sub_asserts.sv
// rom_sub_asserts with ack, data_rdy and activate protocol assertions, bound to rom_sub_top
`default_nettype none

module rom_sub_asserts (
    input wire                            clk,
    input wire                            rst,
    input wire                            sdram_req,
    input wire                            sdram_ack,
    input wire                            data_rdy,
    input wire rom_slot_pkg::sdram_pins_t sdram_pins
);

    timeunit 1ns;
    timeprecision 100ps;

    import rom_slot_pkg::*;

    int   err_cnt = 0;                               // failed assertions so far
    logic fetch_busy;                                // between activate and precharge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_busy <= 1'b0;
        end else if (sdram_pins.cmd == CMD_ACTIVE) begin
            fetch_busy <= 1'b1;
        end else if (sdram_pins.cmd == CMD_PRECHARGE) begin
            fetch_busy <= 1'b0;
        end
    end

    ack_with_req: assert property (@(posedge clk) disable iff (rst)
        sdram_ack |-> sdram_req)
        else begin
            $error("sdram ack seen without a request");
            err_cnt++;
        end

    rdy_one_cycle: assert property (@(posedge clk) disable iff (rst)
        data_rdy |=> !data_rdy)
        else begin
            $error("data_rdy held longer than one cycle");
            err_cnt++;
        end

    no_act_in_fetch: assert property (@(posedge clk) disable iff (rst)
        (sdram_pins.cmd == CMD_ACTIVE) |-> !fetch_busy)
        else begin
            $error("activate issued while a fetch is in progress");
            err_cnt++;
        end

endmodule

bind rom_sub_top rom_sub_asserts u_rom_sub_asserts (
    .clk        (clk),
    .rst        (rst),
    .sdram_req  (sdram_req),
    .sdram_ack  (sdram_ack),
    .data_rdy   (data_rdy),
    .sdram_pins (sdram_pins)
);

`default_nettype wire

//--- dv/rom_sub_stim.txt
# memory block: entry count, then halfword address and data, both hex
# request block: slot address and expected data in hex, hold flag (0 drops cs after one cycle)
8
0010 1234
0011 5678
4a22 9abc
4a23 def0
8300 a55a
8301 0ff1
01fe 2468
01ff 1357
0010 1234 1
0011 5678 1
4a23 def0 1
4a22 9abc 1
0011 5678 1
8301 0ff1 0
8300 a55a 1
8301 0ff1 1
01ff 1357 1
01fe 2468 1

//--- dv/rom_sub_tb.sv
// rom_sub_tb with clock, reset, sdram model, stimulus reader, value check and watchdog
`default_nettype none

`include "rom_slot_cfg.svh"

module rom_sub_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rom_slot_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 5;

    logic        clk;
    logic        rst;
    slot_addr_t  slot_addr;
    logic        slot_cs;
    logic [15:0] sdram_dq;
    slot_data_t  slot_dout;
    logic        slot_ok;
    sdram_pins_t sdram_pins;

    logic [15:0] mem [0:65535];                      // model contents in halfwords
    logic [11:0] open_row [0:3];                     // row opened per bank
    logic [15:0] rd_base;                            // halfword of beat 0
    int          rd_cnt = 0;                         // edges since READ and 0 when idle
    int          active_cnt = 0;
    int          pre_cnt = 0;
    slot_addr_t  req_addr [$];
    slot_data_t  req_data [$];
    bit          req_hold [$];
    bit          loaded = 1'b0;                      // set once the stim file is read

    rom_sub_top u_rom_sub_top (
        .rst        (rst),
        .clk        (clk),
        .slot_addr  (slot_addr),
        .slot_cs    (slot_cs),
        .sdram_dq   (sdram_dq),
        .slot_dout  (slot_dout),
        .slot_ok    (slot_ok),
        .sdram_pins (sdram_pins)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sdram model and command counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (sdram_pins.cmd == CMD_ACTIVE) begin
            open_row[sdram_pins.ba] <= sdram_pins.a[11:0];
            active_cnt              <= active_cnt + 1;
        end
        if (sdram_pins.cmd == CMD_PRECHARGE) begin
            pre_cnt <= pre_cnt + 1;
        end
        if (sdram_pins.cmd == CMD_READ) begin
            rd_base <= 16'({open_row[sdram_pins.ba], sdram_pins.a[8:0]});
            rd_cnt  <= 1;
        end else if (rd_cnt == `ROM_CAS_LAT - 1) begin
            sdram_dq <= mem[rd_base];                // stable at the cas edge
            rd_cnt   <= rd_cnt + 1;
        end else if (rd_cnt == `ROM_CAS_LAT) begin
            sdram_dq <= mem[rd_base + 16'd1];        // second beat from the next column
            rd_cnt   <= 0;
        end else if (rd_cnt != 0) begin
            rd_cnt <= rd_cnt + 1;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    always @(negedge clk) begin
        if (u_rom_sub_top.u_rom_sub_asserts.err_cnt != 0) begin
            stop_run("a protocol assertion on the sdram request path failed");
        end
    end

    initial begin
        wait (loaded);
        #((RST_CYCLES + 2 + 40 * req_addr.size()) * CLK_PERIOD);
        stop_run("watchdog expired before all requests were served");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int          fd;
        int          i;
        int          code;
        int          n_mem;
        int          phase;                          // 0 count, 1 memory, 2 requests
        int          h;
        logic [15:0] a;
        logic [15:0] d;
        string       line;
        logic [14:0] line_tag;                       // word the cache should hold
        bit          line_valid;
        bit          miss;
        int          exp_act;
        int          exp_pre;

        rst       = 1'b1;
        slot_cs   = 1'b0;
        slot_addr = '0;
        sdram_dq  = '0;
        for (i = 0; i < 65536; i++) begin
            mem[i] = 16'(i * 32'h9e37) ^ 16'h5ac3;   // background pattern
        end
        fd = $fopen("dv/rom_sub_stim.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the stimulus file dv/rom_sub_stim.txt");
        end
        phase = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (phase == 0) begin
                code  = $sscanf(line, "%d", n_mem);
                phase = (n_mem > 0) ? 1 : 2;
            end else if (phase == 1) begin
                code = $sscanf(line, "%h %h", a, d);
                if (code != 2) begin
                    stop_run("malformed memory line in the stimulus file");
                end
                mem[a] = d;
                n_mem--;
                if (n_mem == 0) begin
                    phase = 2;
                end
            end else begin
                code = $sscanf(line, "%h %h %d", a, d, h);
                if (code != 3) begin
                    stop_run("malformed request line in the stimulus file");
                end
                req_addr.push_back(a);
                req_data.push_back(d);
                req_hold.push_back(h != 0);
            end
        end
        $fclose(fd);
        if (req_addr.size() == 0) begin
            stop_run("the stimulus file holds no requests");
        end
        loaded = 1'b1;

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset_cmd", 32'(CMD_NOP), 32'(sdram_pins.cmd));
        check_value("reset_ok", 32'd0, 32'(slot_ok));

        line_valid = 1'b0;
        line_tag   = '0;
        exp_act    = 0;
        exp_pre    = 0;
        foreach (req_addr[n]) begin
            miss = !line_valid || (line_tag != req_addr[n][15:1]);
            if (miss) begin
                exp_act++;                           // any other word misses the single line
                exp_pre++;
            end
            @(posedge clk);
            slot_cs   <= 1'b1;
            slot_addr <= req_addr[n];
            if (req_hold[n]) begin
                @(negedge clk);
                while (!slot_ok) @(negedge clk);
                check_value($sformatf("req%0d_data", n), 32'(req_data[n]), 32'(slot_dout));
            end
            @(posedge clk);
            slot_cs <= 1'b0;                         // one cycle of cs when not held
            @(negedge clk);
            while (pre_cnt != exp_pre) @(negedge clk);
            @(negedge clk);                          // an activate reaches the counter an edge later
            check_value($sformatf("req%0d_active", n), exp_act, active_cnt);
            line_tag   = req_addr[n][15:1];
            line_valid = 1'b1;
        end

        repeat (2) @(posedge clk);
        if (u_rom_sub_top.u_rom_sub_asserts.err_cnt != 0) begin
            stop_run("a protocol assertion on the sdram request path failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/rom_slot_pkg.sv
hdl/rom_req.sv
hdl/rom_1slot.sv
hdl/sdram_rd_ctrl.sv
hdl/rom_sub_top.sv
dv/rom_sub_asserts.sv
dv/rom_sub_tb.sv

//--- hdl/rom_1slot.sv
// rom_1slot with data ownership flag around one rom_req engine
`default_nettype none

`include "rom_slot_cfg.svh"

module rom_1slot (
    input  wire                            rst,
    input  wire                            clk,
    input  wire rom_slot_pkg::slot_addr_t  slot_addr,
    input  wire                            slot_cs,
    input  wire                            sdram_ack,
    input  wire                            data_rdy,
    input  wire rom_slot_pkg::rom_word_t   data_read,
    output rom_slot_pkg::slot_data_t       slot_dout,
    output logic                           slot_ok,
    output logic                           sdram_req,
    output rom_slot_pkg::sdram_addr_t      sdram_addr
);

    logic slot_sel;                                  // returning data is ours

    // set by the controller ack, cleared once the line has arrived
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_sel <= 1'b0;
        end else if (sdram_ack) begin
            slot_sel <= 1'b1;
        end else if (data_rdy) begin
            slot_sel <= 1'b0;
        end
    end

    rom_req #(
        .AW (`ROM_SLOT_AW),
        .DW (`ROM_SLOT_DW)
    ) u_slot0 (
        .rst        (rst),
        .clk        (clk),
        .addr       (slot_addr),
        .addr_ok    (slot_cs),                       // cs is a level
        .din        (data_read),
        .din_ok     (data_rdy),
        .we         (slot_sel),
        .sdram_addr (sdram_addr),
        .req        (sdram_req),
        .dout       (slot_dout),
        .data_ok    (slot_ok)
    );

endmodule

`default_nettype wire

//--- hdl/rom_req.sv
// rom_req with one-line cache, miss detection, request level and data lane select
`default_nettype none

`include "rom_slot_cfg.svh"

module rom_req #(
    parameter int AW = `ROM_SLOT_AW,                 // address width in DW units
    parameter int DW = `ROM_SLOT_DW                  // 8, 16 or 32
) (
    input  wire                            rst,
    input  wire                            clk,
    input  wire rom_slot_pkg::slot_addr_t  addr,
    input  wire                            addr_ok,  // client cs level
    input  wire rom_slot_pkg::rom_word_t   din,
    input  wire                            din_ok,   // data_rdy pulse
    input  wire                            we,       // incoming data belongs here
    output rom_slot_pkg::sdram_addr_t      sdram_addr,
    output logic                           req,
    output rom_slot_pkg::slot_data_t       dout,
    output logic                           data_ok
);

    import rom_slot_pkg::*;

    localparam int LANES = 32 / DW;                  // data words per line
    localparam int SHIFT = $clog2(LANES);            // lane bits at the bottom of addr
    localparam int TAGW  = AW - SHIFT;               // word address bits

    logic [TAGW-1:0] addr_tag;                       // word address of current request
    logic [TAGW-1:0] line_tag;                       // word address held in the line
    logic [TAGW-1:0] req_tag;                        // word address being fetched
    logic            line_valid;
    rom_word_t       line_data;
    logic            pending;                        // fetch in flight
    logic            hit;
    logic            miss_new;                       // miss with nothing in flight
    logic [DW-1:0]   lane;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hit and request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign addr_tag = addr[AW-1:SHIFT];              // drop lane bits
    assign hit      = addr_ok & line_valid & (line_tag == addr_tag);
    assign miss_new = addr_ok & ~hit & ~pending;

    // req rises with the miss and stays up until the controller has
    // acked, which the slot flag we reports from the cycle after ack
    assign req = miss_new | (pending & ~we);

    // live address for a new miss, the latched one while in flight
    assign sdram_addr = sdram_addr_t'(pending ? req_tag : addr_tag);

    assign data_ok = hit;                            // combinational on a hit

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending    <= 1'b0;
            line_valid <= 1'b0;
        end else begin
            if (din_ok) begin
                pending <= 1'b0;                     // fetch done
            end else if (req) begin
                pending <= 1'b1;
            end
            if (din_ok && we) begin
                line_valid <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (miss_new) begin
            req_tag <= addr_tag;                     // cs may drop before data returns
        end
        if (din_ok && we) begin
            line_data <= din;
            line_tag  <= req_tag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    generate
        if (SHIFT == 0) begin : g_full_word
            assign lane = line_data[DW-1:0];         // 32-bit slot, whole line
        end else begin : g_lane_sel
            // low lane holds the lowest address, as beats arrive low-first
            assign lane = line_data[addr[SHIFT-1:0]*DW +: DW];
        end
    endgenerate

    assign dout = slot_data_t'(lane);

endmodule

`default_nettype wire

//--- hdl/rom_slot_cfg.svh
// width macros for slot and sdram addressing, sdram read timing in clk cycles
`ifndef ROM_SLOT_CFG_SVH
`define ROM_SLOT_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address and data widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ROM_SDRAMW    22    // 32-bit word address of bank 2 row 12 and column 8 bits
`define ROM_SLOT_AW   16    // slot address counts halfwords
`define ROM_SLOT_DW   16    // slot data width

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sdram timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ROM_T_RCD     2     // activate to read delay, 2 or more
`define ROM_CAS_LAT   2     // read command to first data beat, 2 or more

// Both delays are counted down from value minus two in the controller,
// so values below 2 are not supported.

`endif

//--- hdl/rom_slot_pkg.sv
// vector typedefs, sdram command enum, sdram pin bundle struct and read controller states
`default_nettype none

`include "rom_slot_cfg.svh"

package rom_slot_pkg;

    typedef logic [31:0]             rom_word_t;    // one cache line or sdram word
    typedef logic [`ROM_SDRAMW-1:0]  sdram_addr_t;  // sdram address in 32-bit words
    typedef logic [`ROM_SLOT_AW-1:0] slot_addr_t;   // client address in halfwords
    typedef logic [`ROM_SLOT_DW-1:0] slot_data_t;   // client data

    // encoded as {ras_n, cas_n, we_n}
    typedef enum logic [2:0] {
        CMD_NOP       = 3'b111,
        CMD_ACTIVE    = 3'b011,
        CMD_READ      = 3'b101,
        CMD_PRECHARGE = 3'b010
    } sdram_cmd_e;

    typedef struct packed {
        sdram_cmd_e  cmd;       // command strobes
        logic [1:0]  ba;        // bank select
        logic [12:0] a;         // row on activate, column on read
    } sdram_pins_t;

    typedef enum logic [2:0] {
        IDLE,
        ACT,
        WAIT_RCD,
        RD,
        WAIT_CL,
        BEAT0,
        BEAT1,
        PRE
    } rd_state_e;

endpackage

`default_nettype wire

//--- hdl/rom_sub_top.sv
// rom_sub_top joining the rom slot to the sdram read controller
`default_nettype none

module rom_sub_top (
    input  wire                            rst,
    input  wire                            clk,
    input  wire rom_slot_pkg::slot_addr_t  slot_addr,
    input  wire                            slot_cs,
    input  wire [15:0]                     sdram_dq,    // read data only
    output rom_slot_pkg::slot_data_t       slot_dout,
    output logic                           slot_ok,
    output rom_slot_pkg::sdram_pins_t      sdram_pins
);

    import rom_slot_pkg::*;

    logic        sdram_req;                          // slot wants a line
    logic        sdram_ack;
    logic        data_rdy;
    sdram_addr_t sdram_addr;
    rom_word_t   data_read;                          // assembled line

    rom_1slot u_rom_1slot (
        .rst        (rst),
        .clk        (clk),
        .slot_addr  (slot_addr),
        .slot_cs    (slot_cs),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read),
        .slot_dout  (slot_dout),
        .slot_ok    (slot_ok),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr)
    );

    sdram_rd_ctrl u_sdram_rd_ctrl (
        .rst        (rst),
        .clk        (clk),
        .req        (sdram_req),
        .addr       (sdram_addr),
        .dq         (sdram_dq),
        .ack        (sdram_ack),
        .pins       (sdram_pins),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

endmodule

`default_nettype wire

//--- hdl/sdram_rd_ctrl.sv
// sdram_rd_ctrl read sequencer with activate, read, cas wait, two-beat capture and precharge
`default_nettype none

`include "rom_slot_cfg.svh"

module sdram_rd_ctrl (
    input  wire                            rst,
    input  wire                            clk,
    input  wire                            req,      // request level
    input  wire rom_slot_pkg::sdram_addr_t addr,     // 32-bit word address
    input  wire [15:0]                     dq,
    output logic                           ack,      // pulse on leaving IDLE
    output rom_slot_pkg::sdram_pins_t      pins,
    output logic                           data_rdy, // pulse with the full word
    output rom_slot_pkg::rom_word_t        data_read
);

    import rom_slot_pkg::*;

    localparam int COLW = 8;                         // column bits in word units
    localparam int ROWW = 12;

    rd_state_e       state;
    logic [2:0]      cnt;                            // rcd and cas wait counter
    sdram_addr_t     addr_q;                         // address of the fetch in flight
    logic [1:0]      q_bank;
    logic [COLW-1:0] q_col;
    logic            start;

    assign start  = (state == IDLE) && req;
    assign q_bank = addr_q[`ROM_SDRAMW-1 -: 2];
    assign q_col  = addr_q[COLW-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // pins are registered, so each command shows in the cycle of its state.
    // Beat 0 is valid on dq CAS_LAT cycles after the READ cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            cnt      <= '0;
            ack      <= 1'b0;
            data_rdy <= 1'b0;
            pins     <= '{cmd: CMD_NOP, ba: 2'd0, a: 13'd0};
        end else begin
            ack      <= 1'b0;                        // strobes last one cycle
            data_rdy <= 1'b0;
            pins.cmd <= CMD_NOP;
            case (state)
                IDLE: begin
                    if (req) begin
                        state    <= ACT;
                        ack      <= 1'b1;
                        pins.cmd <= CMD_ACTIVE;
                        pins.ba  <= addr[`ROM_SDRAMW-1 -: 2];
                        pins.a   <= 13'(addr[COLW +: ROWW]);     // open the row
                    end
                end
                ACT: begin
                    state <= WAIT_RCD;
                    cnt   <= 3'(`ROM_T_RCD - 2);
                end
                WAIT_RCD: begin
                    if (cnt == '0) begin
                        state    <= RD;
                        pins.cmd <= CMD_READ;
                        pins.ba  <= q_bank;
                        pins.a   <= 13'({q_col, 1'b0});          // halfword column, a10 low
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                RD: begin
                    state <= WAIT_CL;
                    cnt   <= 3'(`ROM_CAS_LAT - 2);
                end
                WAIT_CL: begin
                    if (cnt == '0) begin
                        state <= BEAT0;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                BEAT0: begin
                    state <= BEAT1;                  // low halfword sampled
                end
                BEAT1: begin
                    state    <= PRE;
                    data_rdy <= 1'b1;                // word complete next cycle
                end
                PRE: begin
                    state    <= IDLE;
                    pins.cmd <= CMD_PRECHARGE;       // after data_rdy
                    pins.ba  <= q_bank;
                    pins.a   <= 13'h0400;            // a10 for all banks
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address latch and beat capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr;
        end
        if (state == BEAT0) begin
            data_read[15:0] <= dq;                   // first beat is the low half
        end
        if (state == BEAT1) begin
            data_read[31:16] <= dq;
        end
    end

endmodule

`default_nettype wire
